//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataW = 16;
    localparam int addrW = 8;
    localparam int memWords = 2 ** addrW;
    localparam int gprCount = 8;
    localparam int regSelW = $clog2(gprCount);
    localparam int shiftW = $clog2(dataW);
    localparam int stateCount = 33;
    localparam int stateW = $clog2(stateCount);

    typedef logic [dataW-1:0] word_t;
    typedef logic [addrW-1:0] addr_t;
    typedef logic [regSelW-1:0] regSel_t;
    typedef logic [stateW-1:0] step_t;

    // field positions in the instruction word
    localparam int opcodeLsb = 12;
    localparam int rdLsb = 8;
    localparam int rsLsb = 4;
    localparam int immW = 8;

    typedef enum logic [3:0] {
        opNop, opMov, opLdr, opStr, opCmp, opB, opBgt, opBlt,
        opBeq, opAdd, opSub, opLsr, opAnd, opOr, opMvn, opHlt
    } opcode_t;

    // micro-step indices, routine starts only
    localparam step_t fetch1 = 0;
    localparam step_t fetch2 = 1;
    localparam step_t fetch3 = 2;
    localparam step_t nop1 = 3;
    localparam step_t mov1 = 4;
    // ldr and str take three steps each
    localparam step_t ldr1 = 5;
    localparam step_t str1 = 8;
    localparam step_t cmp1 = 11;
    localparam step_t b1 = 12;
    localparam step_t bgt1 = 13;
    localparam step_t blt1 = 14;
    localparam step_t beq1 = 15;
    // two steps per ALU op
    localparam step_t add1 = 16;
    localparam step_t sub1 = 18;
    localparam step_t lsr1 = 20;
    localparam step_t and1 = 22;
    localparam step_t or1 = 24;
    localparam step_t mvn1 = 26;
    localparam step_t hlt1 = 28;

    typedef enum logic [3:0] {
        busPc, busDr, busAr, busAc, busMem, busTr, busRop1, busRop2, busGpr1
    } busSel_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluLsr, aluAnd, aluOr, aluMvn
    } aluSel_t;

    typedef struct packed {
        logic    rselLoad;
        logic    rop1Load;
        logic    rop2Load;
        logic    trLoad;
        logic    arLoad;
        logic    pcLoad;
        logic    drLoad;
        logic    acLoad;
        logic    irLoad;
        logic    gprLoad;
        logic    memLoad;
        logic    pcInc;
        logic    cntLd;
        logic    cntInc;
        logic    cntClr;
        aluSel_t aluSel;
        busSel_t busSel;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

//--- hw/control/stateSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          run,
    input  cpuPkg::ctrl_t                 ctrl,
    input  cpuPkg::opcode_t               opcode,
    output logic [cpuPkg::stateCount-1:0] state,
    output logic                          halted
);

    cpuPkg::step_t count;
    cpuPkg::step_t routineStart;

    // first step of each instruction's routine
    always_comb begin
        case (opcode)
            cpuPkg::opNop: routineStart = cpuPkg::nop1;
            cpuPkg::opMov: routineStart = cpuPkg::mov1;
            cpuPkg::opLdr: routineStart = cpuPkg::ldr1;
            cpuPkg::opStr: routineStart = cpuPkg::str1;
            cpuPkg::opCmp: routineStart = cpuPkg::cmp1;
            cpuPkg::opB:   routineStart = cpuPkg::b1;
            cpuPkg::opBgt: routineStart = cpuPkg::bgt1;
            cpuPkg::opBlt: routineStart = cpuPkg::blt1;
            cpuPkg::opBeq: routineStart = cpuPkg::beq1;
            cpuPkg::opAdd: routineStart = cpuPkg::add1;
            cpuPkg::opSub: routineStart = cpuPkg::sub1;
            cpuPkg::opLsr: routineStart = cpuPkg::lsr1;
            cpuPkg::opAnd: routineStart = cpuPkg::and1;
            cpuPkg::opOr:  routineStart = cpuPkg::or1;
            cpuPkg::opMvn: routineStart = cpuPkg::mvn1;
            cpuPkg::opHlt: routineStart = cpuPkg::hlt1;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count  <= cpuPkg::fetch1;
            halted <= 1'b0;
        end else if (run && !halted) begin
            // hlt freezes the counter for good
            if (ctrl.halt)
                halted <= 1'b1;
            else if (ctrl.cntClr)
                count <= cpuPkg::fetch1;
            else if (ctrl.cntLd)
                count <= routineStart;
            else if (ctrl.cntInc)
                count <= count + 1'b1;
        end
    end

    // no step is active until run goes high
    always_comb begin
        state = '0;
        if (run)
            state[count] = 1'b1;
    end

    assert property (@(posedge clk) disable iff (!arstN) run |-> $onehot(state));

endmodule

`default_nettype wire

//--- hw/control/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  logic [cpuPkg::stateCount-1:0] state,
    input  cpuPkg::flags_t                flags,
    output cpuPkg::ctrl_t                 ctrl
);

    always_comb begin
        ctrl = '0;
        case (1'b1)
            state[cpuPkg::fetch1]: begin
                ctrl.busSel = cpuPkg::busPc;
                ctrl.arLoad = 1'b1;
                ctrl.cntInc = 1'b1;
            end
            state[cpuPkg::fetch2]: begin
                ctrl.busSel = cpuPkg::busMem;
                ctrl.drLoad = 1'b1;
                ctrl.pcInc  = 1'b1;
                ctrl.cntInc = 1'b1;
            end
            // operand fields are taken off the bus while IR loads
            state[cpuPkg::fetch3]: begin
                ctrl.busSel   = cpuPkg::busDr;
                ctrl.irLoad   = 1'b1;
                ctrl.rselLoad = 1'b1;
                ctrl.rop1Load = 1'b1;
                ctrl.rop2Load = 1'b1;
                ctrl.cntLd    = 1'b1;
            end
            state[cpuPkg::nop1]: ctrl.cntClr = 1'b1;
            state[cpuPkg::mov1]: begin
                ctrl.busSel  = cpuPkg::busRop2;
                ctrl.gprLoad = 1'b1;
                ctrl.cntClr  = 1'b1;
            end
            // address from the immediate
            state[cpuPkg::ldr1], state[cpuPkg::str1]: begin
                ctrl.busSel = cpuPkg::busRop2;
                ctrl.arLoad = 1'b1;
                ctrl.cntInc = 1'b1;
            end
            state[cpuPkg::ldr1 + 1]: begin
                ctrl.busSel = cpuPkg::busMem;
                ctrl.trLoad = 1'b1;
                ctrl.cntInc = 1'b1;
            end
            state[cpuPkg::ldr1 + 2]: begin
                ctrl.busSel  = cpuPkg::busTr;
                ctrl.gprLoad = 1'b1;
                ctrl.cntClr  = 1'b1;
            end
            state[cpuPkg::str1 + 1]: begin
                ctrl.busSel = cpuPkg::busGpr1;
                ctrl.drLoad = 1'b1;
                ctrl.cntInc = 1'b1;
            end
            state[cpuPkg::str1 + 2]: begin
                ctrl.memLoad = 1'b1;
                ctrl.cntClr  = 1'b1;
            end
            // result goes to AC only, flags are what matter
            state[cpuPkg::cmp1]: begin
                ctrl.aluSel = cpuPkg::aluSub;
                ctrl.acLoad = 1'b1;
                ctrl.cntClr = 1'b1;
            end
            state[cpuPkg::b1], state[cpuPkg::bgt1], state[cpuPkg::blt1],
            state[cpuPkg::beq1]: begin
                ctrl.busSel = cpuPkg::busRop2;
                ctrl.pcLoad = state[cpuPkg::b1]
                    || (state[cpuPkg::bgt1] && !flags.z && (flags.n == flags.v))
                    || (state[cpuPkg::blt1] && (flags.n != flags.v))
                    || (state[cpuPkg::beq1] && flags.z);
                ctrl.cntClr = 1'b1;
            end
            // first ALU step computes into AC
            state[cpuPkg::add1], state[cpuPkg::sub1], state[cpuPkg::lsr1],
            state[cpuPkg::and1], state[cpuPkg::or1], state[cpuPkg::mvn1]: begin
                ctrl.acLoad = 1'b1;
                ctrl.cntInc = 1'b1;
                if (state[cpuPkg::sub1])
                    ctrl.aluSel = cpuPkg::aluSub;
                else if (state[cpuPkg::lsr1])
                    ctrl.aluSel = cpuPkg::aluLsr;
                else if (state[cpuPkg::and1])
                    ctrl.aluSel = cpuPkg::aluAnd;
                else if (state[cpuPkg::or1])
                    ctrl.aluSel = cpuPkg::aluOr;
                else if (state[cpuPkg::mvn1])
                    ctrl.aluSel = cpuPkg::aluMvn;
                else
                    ctrl.aluSel = cpuPkg::aluAdd;
            end
            // then AC back to rd
            state[cpuPkg::add1 + 1], state[cpuPkg::sub1 + 1], state[cpuPkg::lsr1 + 1],
            state[cpuPkg::and1 + 1], state[cpuPkg::or1 + 1], state[cpuPkg::mvn1 + 1]: begin
                ctrl.busSel  = cpuPkg::busAc;
                ctrl.gprLoad = 1'b1;
                ctrl.cntClr  = 1'b1;
            end
            state[cpuPkg::hlt1]: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/datapath/busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module busDatapath (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::ctrl_t   ctrl,
    input  cpuPkg::word_t   aluResult,
    input  cpuPkg::word_t   memRdata,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::word_t   gpr1,
    output cpuPkg::word_t   rop1,
    output cpuPkg::addr_t   memAddr,
    output cpuPkg::word_t   memWdata,
    input  cpuPkg::regSel_t peekSel,
    output cpuPkg::word_t   peekData
);

    cpuPkg::addr_t pc;
    cpuPkg::addr_t ar;
    cpuPkg::word_t dr;
    cpuPkg::word_t tr;
    cpuPkg::word_t ac;
    cpuPkg::word_t ir;
    cpuPkg::word_t irNext;
    cpuPkg::word_t bus;
    cpuPkg::regSel_t rsel;
    logic [cpuPkg::immW-1:0] rop2;
    cpuPkg::word_t gpr [cpuPkg::gprCount];

    always_comb begin
        case (ctrl.busSel)
            cpuPkg::busPc:   bus = cpuPkg::word_t'(pc);
            cpuPkg::busDr:   bus = dr;
            cpuPkg::busAr:   bus = cpuPkg::word_t'(ar);
            cpuPkg::busAc:   bus = ac;
            cpuPkg::busMem:  bus = memRdata;
            cpuPkg::busTr:   bus = tr;
            cpuPkg::busRop1: bus = rop1;
            cpuPkg::busRop2: bus = cpuPkg::word_t'(rop2);
            cpuPkg::busGpr1: bus = gpr1;
            default:         bus = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc   <= '0;
            ar   <= '0;
            dr   <= '0;
            tr   <= '0;
            ac   <= '0;
            ir   <= '0;
            rsel <= '0;
            rop1 <= '0;
            rop2 <= '0;
            for (int i = 0; i < cpuPkg::gprCount; i++)
                gpr[i] <= '0;
        end else begin
            if (ctrl.pcLoad)
                pc <= bus[cpuPkg::addrW-1:0];
            else if (ctrl.pcInc)
                pc <= pc + 1'b1;
            if (ctrl.arLoad)
                ar <= bus[cpuPkg::addrW-1:0];
            if (ctrl.drLoad)
                dr <= bus;
            if (ctrl.trLoad)
                tr <= bus;
            if (ctrl.acLoad)
                ac <= aluResult;
            if (ctrl.irLoad)
                ir <= bus;
            if (ctrl.rselLoad)
                rsel <= bus[cpuPkg::rdLsb +: cpuPkg::regSelW];
            // rs is read out of the register file, not the bus
            if (ctrl.rop1Load)
                rop1 <= gpr[bus[cpuPkg::rsLsb +: cpuPkg::regSelW]];
            if (ctrl.rop2Load)
                rop2 <= bus[cpuPkg::immW-1:0];
            if (ctrl.gprLoad)
                gpr[rsel] <= bus;
        end
    end

    // sequencer needs the opcode in the same step IR loads
    assign irNext = ctrl.irLoad ? bus : ir;
    assign opcode = cpuPkg::opcode_t'(irNext[cpuPkg::opcodeLsb +: $bits(cpuPkg::opcode_t)]);
    assign gpr1 = gpr[rsel];
    assign memAddr = ar;
    assign memWdata = dr;
    assign peekData = gpr[peekSel];

    assert property (@(posedge clk) disable iff (!arstN)
        (ctrl.pcLoad || ctrl.arLoad || ctrl.drLoad || ctrl.trLoad || ctrl.irLoad
            || ctrl.gprLoad) |-> (ctrl.busSel <= cpuPkg::busGpr1));

endmodule

`default_nettype wire

//--- hw/datapath/aluFlags.sv
`timescale 1ns/1ps
`default_nettype none

module aluFlags (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::ctrl_t  ctrl,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  result,
    output cpuPkg::flags_t flags
);

    logic carry;
    logic overflow;

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (ctrl.aluSel)
            cpuPkg::aluAdd: begin
                {carry, result} = {1'b0, a} + {1'b0, b};
                overflow = (a[cpuPkg::dataW-1] == b[cpuPkg::dataW-1])
                    && (result[cpuPkg::dataW-1] != a[cpuPkg::dataW-1]);
            end
            // carry out here means no borrow
            cpuPkg::aluSub: begin
                {carry, result} = {1'b0, a} + {1'b0, ~b} + 1'b1;
                overflow = (a[cpuPkg::dataW-1] != b[cpuPkg::dataW-1])
                    && (result[cpuPkg::dataW-1] != a[cpuPkg::dataW-1]);
            end
            cpuPkg::aluLsr: result = a >> b[cpuPkg::shiftW-1:0];
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluMvn: result = ~b;
            default:        result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (ctrl.acLoad) begin
            flags.n <= result[cpuPkg::dataW-1];
            flags.z <= (result == '0);
            flags.c <= carry;
            flags.v <= overflow;
        end
    end

endmodule

`default_nettype wire

//--- hw/wordMemory.sv
`timescale 1ns/1ps
`default_nettype none

module wordMemory (
    input  logic          clk,
    input  logic          memLoad,
    input  cpuPkg::addr_t addr,
    input  cpuPkg::word_t wdata,
    output cpuPkg::word_t rdata,
    input  logic          progWe,
    input  cpuPkg::addr_t progAddr,
    input  cpuPkg::word_t progData
);

    cpuPkg::word_t mem [cpuPkg::memWords];

    // program load port wins, though both never fire together
    always_ff @(posedge clk) begin
        if (progWe)
            mem[progAddr] <= progData;
        else if (memLoad)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr];

    assert property (@(posedge clk) !(progWe && memLoad));

endmodule

`default_nettype wire

//--- hw/tinyCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tinyCpu (
    input  logic            clk,
    input  logic            arstN,
    input  logic            run,
    input  logic            progWe,
    input  cpuPkg::addr_t   progAddr,
    input  cpuPkg::word_t   progData,
    input  cpuPkg::regSel_t peekSel,
    output cpuPkg::word_t   peekData,
    output logic            halted
);

    logic [cpuPkg::stateCount-1:0] state;
    cpuPkg::ctrl_t   ctrl;
    cpuPkg::flags_t  flags;
    cpuPkg::opcode_t opcode;
    cpuPkg::word_t   gpr1;
    cpuPkg::word_t   rop1;
    cpuPkg::word_t   aluResult;
    cpuPkg::word_t   memRdata;
    cpuPkg::word_t   memWdata;
    cpuPkg::addr_t   memAddr;

    // control path
    stateSequencer i_stateSequencer (
        .clk    (clk),
        .arstN  (arstN),
        .run    (run),
        .ctrl   (ctrl),
        .opcode (opcode),
        .state  (state),
        .halted (halted)
    );

    controlDecoder i_controlDecoder (
        .state (state),
        .flags (flags),
        .ctrl  (ctrl)
    );

    // datapath
    busDatapath i_busDatapath (
        .clk       (clk),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .memRdata  (memRdata),
        .opcode    (opcode),
        .gpr1      (gpr1),
        .rop1      (rop1),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .peekSel   (peekSel),
        .peekData  (peekData)
    );

    aluFlags i_aluFlags (
        .clk    (clk),
        .arstN  (arstN),
        .ctrl   (ctrl),
        .a      (gpr1),
        .b      (rop1),
        .result (aluResult),
        .flags  (flags)
    );

    wordMemory i_wordMemory (
        .clk      (clk),
        .memLoad  (ctrl.memLoad),
        .addr     (memAddr),
        .wdata    (memWdata),
        .rdata    (memRdata),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData)
    );

endmodule

`default_nettype wire

//--- bench/tinyCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module tinyCpuTb;

    localparam int programCount = 30;
    localparam int haltTimeout = 2000;
    localparam int dataBase = 128;

    logic            clk;
    logic            arstN;
    logic            run;
    logic            progWe;
    cpuPkg::addr_t   progAddr;
    cpuPkg::word_t   progData;
    cpuPkg::regSel_t peekSel;
    cpuPkg::word_t   peekData;
    logic            halted;

    int seed = 33093;
    cpuPkg::word_t  image [cpuPkg::memWords];
    cpuPkg::word_t  modelMem [cpuPkg::memWords];
    cpuPkg::word_t  modelGpr [cpuPkg::gprCount];
    cpuPkg::flags_t modelFlags;

    tinyCpu i_tinyCpu (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .peekSel  (peekSel),
        .peekData (peekData),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic cpuPkg::word_t encImm(input cpuPkg::opcode_t op, input int rd,
        input int imm);
        return {op, 1'b0, 3'(rd), 8'(imm)};
    endfunction

    function automatic cpuPkg::word_t encReg(input cpuPkg::opcode_t op, input int rd,
        input int rs);
        return {op, 1'b0, 3'(rd), 1'b0, 3'(rs), 4'h0};
    endfunction

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    // ALU behavior straight from the ISA flag rules
    task automatic modelAlu(input cpuPkg::opcode_t op, input cpuPkg::word_t a,
        input cpuPkg::word_t b, output cpuPkg::word_t r);
        int wide;
        int signedWide;
        modelFlags.c = 1'b0;
        modelFlags.v = 1'b0;
        case (op)
            cpuPkg::opAdd: begin
                wide = int'(a) + int'(b);
                signedWide = int'($signed(a)) + int'($signed(b));
                r = wide[15:0];
                modelFlags.c = wide > 32'hffff;
                modelFlags.v = (signedWide > 32767) || (signedWide < -32768);
            end
            cpuPkg::opSub, cpuPkg::opCmp: begin
                signedWide = int'($signed(a)) - int'($signed(b));
                r = a - b;
                // carry set when nothing was borrowed
                modelFlags.c = a >= b;
                modelFlags.v = (signedWide > 32767) || (signedWide < -32768);
            end
            cpuPkg::opLsr: r = a >> b[3:0];
            cpuPkg::opAnd: r = a & b;
            cpuPkg::opOr:  r = a | b;
            cpuPkg::opMvn: r = ~b;
            default:       r = '0;
        endcase
        modelFlags.n = r[15];
        modelFlags.z = (r == '0);
    endtask

    // interpret the image and count cycles up to the one where halted shows
    task automatic runModel(output int cycles);
        cpuPkg::word_t   ins;
        cpuPkg::opcode_t op;
        cpuPkg::addr_t   pc;
        cpuPkg::regSel_t rd;
        cpuPkg::regSel_t rs;
        cpuPkg::addr_t   imm;
        cpuPkg::word_t   result;
        logic            taken;
        logic            done;
        modelMem = image;
        foreach (modelGpr[i])
            modelGpr[i] = '0;
        modelFlags = '0;
        pc = '0;
        done = 1'b0;
        cycles = 1;
        while (!done) begin
            ins = modelMem[pc];
            op = cpuPkg::opcode_t'(ins[15:12]);
            rd = ins[10:8];
            rs = ins[6:4];
            imm = ins[7:0];
            pc = pc + 1'b1;
            // three fetch steps for every instruction
            cycles += 3;
            case (op)
                cpuPkg::opNop: cycles += 1;
                cpuPkg::opMov: begin
                    modelGpr[rd] = {8'h00, imm};
                    cycles += 1;
                end
                cpuPkg::opLdr: begin
                    modelGpr[rd] = modelMem[imm];
                    cycles += 3;
                end
                cpuPkg::opStr: begin
                    modelMem[imm] = modelGpr[rd];
                    cycles += 3;
                end
                cpuPkg::opCmp: begin
                    modelAlu(op, modelGpr[rd], modelGpr[rs], result);
                    cycles += 1;
                end
                cpuPkg::opB, cpuPkg::opBgt, cpuPkg::opBlt, cpuPkg::opBeq: begin
                    taken = (op == cpuPkg::opB)
                        || (op == cpuPkg::opBgt && !modelFlags.z
                            && (modelFlags.n == modelFlags.v))
                        || (op == cpuPkg::opBlt && (modelFlags.n != modelFlags.v))
                        || (op == cpuPkg::opBeq && modelFlags.z);
                    if (taken)
                        pc = imm;
                    cycles += 1;
                end
                cpuPkg::opHlt: begin
                    done = 1'b1;
                    cycles += 1;
                end
                default: begin
                    modelAlu(op, modelGpr[rd], modelGpr[rs], result);
                    modelGpr[rd] = result;
                    cycles += 2;
                end
            endcase
        end
    endtask

    // random program with forward branches only, so it always reaches hlt
    task automatic buildProgram();
        int len;
        int pc;
        int storeReg;
        int storeAddr;
        len = cpuPkg::gprCount + 12 + rnd(24);
        for (int a = 0; a < cpuPkg::memWords; a++) begin
            if (a >= dataBase)
                image[a] = 16'(rnd(65536));
            else
                image[a] = {cpuPkg::opHlt, 4'h0, 8'(a)};
        end
        for (int r = 0; r < cpuPkg::gprCount; r++)
            image[r] = encImm(cpuPkg::opMov, r, rnd(256));
        pc = cpuPkg::gprCount;
        while (pc < len - 1) begin
            case (rnd(10))
                0, 1, 2, 3: image[pc] = encReg(
                    cpuPkg::opcode_t'(4'(int'(cpuPkg::opAdd) + rnd(6))), rnd(8), rnd(8));
                4: image[pc] = encImm(cpuPkg::opMov, rnd(8), rnd(256));
                5: image[pc] = encImm(cpuPkg::opLdr, rnd(8), dataBase + rnd(128));
                6: begin
                    if (pc + 2 < len) begin
                        storeReg = rnd(8);
                        storeAddr = dataBase + rnd(128);
                        image[pc] = encImm(cpuPkg::opStr, storeReg, storeAddr);
                        pc++;
                        // read the stored word back into a different register
                        image[pc] = encImm(cpuPkg::opLdr, (storeReg + 1 + rnd(7)) % 8,
                            storeAddr);
                    end else begin
                        image[pc] = encImm(cpuPkg::opStr, rnd(8), dataBase + rnd(128));
                    end
                end
                7: begin
                    if (pc + 2 < len) begin
                        image[pc] = encReg(cpuPkg::opCmp, rnd(8), rnd(8));
                        pc++;
                        image[pc] = encImm(
                            cpuPkg::opcode_t'(4'(int'(cpuPkg::opBgt) + rnd(3))), 0,
                            pc + 1 + rnd(len - 1 - pc));
                    end else begin
                        image[pc] = encImm(cpuPkg::opNop, 0, 0);
                    end
                end
                8: image[pc] = encImm(cpuPkg::opB, 0, pc + 1 + rnd(len - 1 - pc));
                default: image[pc] = encImm(cpuPkg::opNop, 0, 0);
            endcase
            pc++;
        end
        image[len - 1] = encImm(cpuPkg::opHlt, 0, 0);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        arstN = 1'b0;
        run = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
    endtask

    task automatic loadMemory();
        for (int a = 0; a < cpuPkg::memWords; a++) begin
            @(posedge clk);
            #1;
            progWe = 1'b1;
            progAddr = cpuPkg::addr_t'(a);
            progData = image[a];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
    endtask

    task automatic runProgram(input int index);
        int expectedCycles;
        int cycles;
        buildProgram();
        runModel(expectedCycles);
        applyReset();
        loadMemory();
        // idle state after reset
        checkValue("halted", 32'(halted), 32'd0);
        for (int r = 0; r < cpuPkg::gprCount; r++) begin
            @(posedge clk);
            #1;
            peekSel = 3'(r);
            #1;
            checkValue($sformatf("peekData r%0d before run", r), 32'(peekData), 32'd0);
        end
        @(posedge clk);
        #1;
        run = 1'b1;
        cycles = 1;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > haltTimeout) begin
                $display("program %0d did not halt within %0d cycles", index, haltTimeout);
                abortRun();
            end
        end
        checkValue("cycles", 32'(cycles), 32'(expectedCycles));
        for (int r = 0; r < cpuPkg::gprCount; r++) begin
            @(posedge clk);
            #1;
            peekSel = 3'(r);
            #1;
            checkValue($sformatf("peekData r%0d", r), 32'(peekData), 32'(modelGpr[r]));
        end
        // halted has to hold once set
        checkValue("halted after peeks", 32'(halted), 32'd1);
        run = 1'b0;
    endtask

    initial begin
        arstN = 1'b0;
        run = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        peekSel = '0;
        for (int p = 0; p < programCount; p++)
            runProgram(p);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tinyCpu.f
common/cpuPkg.sv
hw/control/stateSequencer.sv
hw/control/controlDecoder.sv
hw/datapath/busDatapath.sv
hw/datapath/aluFlags.sv
hw/wordMemory.sv
hw/tinyCpu.sv
bench/tinyCpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tinyCpuTb
FILELIST  ?= tinyCpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
